// ==== Bender.yml ====
package:
  name: alpha_compositor

export_include_dirs:
  - source

sources:
  - files:
      - source/blend_pkg.sv
      - source/entry_fifo.sv
      - source/alpha_blend_pipe.sv
      - source/blend_sequencer.sv
      - source/alpha_compositor.sv
  - target: test
    files:
      - test/frame_memory_model.sv
      - test/compositor_tb.sv

// ==== flist.f ====
+incdir+source
source/blend_pkg.sv
source/entry_fifo.sv
source/alpha_blend_pipe.sv
source/blend_sequencer.sv
source/alpha_compositor.sv
test/frame_memory_model.sv
test/compositor_tb.sv

// ==== source/alpha_blend_pipe.sv ====
// ##############################
// alpha_blend_pipe: three-stage
// per-channel blend. Multiply,
// add, then divide by 255, with
// a result tag carried along.
// ##############################

`include "blend_settings.svh"

module alpha_blend_pipe
(
	input logic clk,
	input logic reset,
	input logic in_valid,
	input blend_pkg::rgb_t src_rgb,
	input blend_pkg::channel_t alpha,
	input blend_pkg::rgb_t dst_rgb,
	input blend_pkg::res_entry_t in_tag,
	output logic out_valid,
	output blend_pkg::res_entry_t out_entry,
	output logic [1:0] in_flight
);

	import blend_pkg::*;

	localparam int PROD_W = 2 * `BLEND_CHANNEL_W;

	channel_t inv_alpha;
	channel_t src_ch [3];
	channel_t dst_ch [3];
	logic [PROD_W-1:0] prod_src [3];
	logic [PROD_W-1:0] prod_dst [3];
	logic [PROD_W-1:0] sum [3];
	logic [PROD_W-1:0] quo [3];
	res_entry_t tag_s1;
	res_entry_t tag_s2;
	logic [`BLEND_LATENCY-1:0] valid_sr;

	assign inv_alpha = 8'd255 - alpha;

	// Index 0 is red, 2 is blue.
	assign src_ch[0] = src_rgb.r;
	assign src_ch[1] = src_rgb.g;
	assign src_ch[2] = src_rgb.b;
	assign dst_ch[0] = dst_rgb.r;
	assign dst_ch[1] = dst_rgb.g;
	assign dst_ch[2] = dst_rgb.b;

	always_ff @(posedge clk)
	begin
		if (!reset)
			valid_sr <= '0;
		else
			valid_sr <= {valid_sr[`BLEND_LATENCY-2:0], in_valid};  // Pipe never stalls.
	end

	always_ff @(posedge clk)
	begin
		for (int c = 0; c < 3; c++)
		begin
			prod_src[c] <= PROD_W'(src_ch[c]) * PROD_W'(alpha);
			prod_dst[c] <= PROD_W'(dst_ch[c]) * PROD_W'(inv_alpha);
			sum[c] <= prod_src[c] + prod_dst[c];  // At most 255 * 255, no carry out.
		end
		tag_s1 <= in_tag;
		tag_s2 <= tag_s1;
		out_entry.addr <= tag_s2.addr;
		out_entry.last <= tag_s2.last;
		out_entry.rgb.r <= quo[0][`BLEND_CHANNEL_W-1:0];
		out_entry.rgb.g <= quo[1][`BLEND_CHANNEL_W-1:0];
		out_entry.rgb.b <= quo[2][`BLEND_CHANNEL_W-1:0];
	end

	// Truncating divide, the third stage sits right behind it.
	always_comb
	begin
		for (int c = 0; c < 3; c++)
			quo[c] = sum[c] / PROD_W'(255);
	end

	always_comb
	begin
		in_flight = '0;
		for (int i = 0; i < `BLEND_LATENCY; i++)
			in_flight = in_flight + 2'(valid_sr[i]);  // Feeds the credit check.
	end

	assign out_valid = valid_sr[`BLEND_LATENCY-1];

	assert property (@(posedge clk) disable iff (!reset)
		valid_sr[1] |-> (quo[0] <= 255 && quo[1] <= 255 && quo[2] <= 255))
		else $error("alpha_blend_pipe: blended channel exceeds 255.");

endmodule

// ==== source/alpha_compositor.sv ====
// ##############################
// alpha_compositor: top level.
// Source FIFO, sequencer, blend
// pipe and result FIFO.
// ##############################

`include "blend_settings.svh"

module alpha_compositor
(
	input logic clk,
	input logic reset,
	input logic src_valid,
	output logic src_ready,
	input blend_pkg::pixel_addr_t src_addr,
	input blend_pkg::channel_t src_r,
	input blend_pkg::channel_t src_g,
	input blend_pkg::channel_t src_b,
	input blend_pkg::channel_t src_a,
	input logic src_last,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output blend_pkg::pixel_addr_t wb_adr,
	output blend_pkg::rgb_t wb_dat_w,
	input blend_pkg::rgb_t wb_dat_r,
	input logic wb_ack,
	output logic frame_done
);

	import blend_pkg::*;

	src_entry_t src_entry;
	src_entry_t src_head;
	logic src_push;
	logic src_pop;
	logic src_full;
	logic src_empty;
	logic blend_valid;
	rgb_t blend_src;
	channel_t blend_alpha;
	rgb_t blend_dst;
	res_entry_t blend_tag;
	logic pipe_valid;
	res_entry_t pipe_entry;
	logic [1:0] pipe_in_flight;
	res_entry_t res_head;
	logic res_pop;
	logic [$clog2(`BLEND_RES_DEPTH):0] res_count;

	assign src_ready = !src_full;
	assign src_push = src_valid && src_ready;
	assign src_entry.addr = src_addr;
	assign src_entry.rgb.r = src_r;
	assign src_entry.rgb.g = src_g;
	assign src_entry.rgb.b = src_b;
	assign src_entry.alpha = src_a;
	assign src_entry.last = src_last;

	entry_fifo #(.entry_t(src_entry_t), .DEPTH(`BLEND_SRC_DEPTH)) src_fifo
	(
		.clk(clk),
		.reset(reset),
		.push(src_push),
		.push_data(src_entry),
		.pop(src_pop),
		.head(src_head),
		.full(src_full),
		.empty(src_empty),
		.count()
	);

	blend_sequencer sequencer
	(
		.clk(clk),
		.reset(reset),
		.src_empty(src_empty),
		.src_head(src_head),
		.src_pop(src_pop),
		.blend_valid(blend_valid),
		.blend_src(blend_src),
		.blend_alpha(blend_alpha),
		.blend_dst(blend_dst),
		.blend_tag(blend_tag),
		.pipe_in_flight(pipe_in_flight),
		.res_count(res_count),
		.res_head(res_head),
		.res_pop(res_pop),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.frame_done(frame_done)
	);

	alpha_blend_pipe pipe
	(
		.clk(clk),
		.reset(reset),
		.in_valid(blend_valid),
		.src_rgb(blend_src),
		.alpha(blend_alpha),
		.dst_rgb(blend_dst),
		.in_tag(blend_tag),
		.out_valid(pipe_valid),
		.out_entry(pipe_entry),
		.in_flight(pipe_in_flight)
	);

	// Credits in the sequencer keep this FIFO from overflowing.
	entry_fifo #(.entry_t(res_entry_t), .DEPTH(`BLEND_RES_DEPTH)) res_fifo
	(
		.clk(clk),
		.reset(reset),
		.push(pipe_valid),
		.push_data(pipe_entry),
		.pop(res_pop),
		.head(res_head),
		.full(),
		.empty(),
		.count(res_count)
	);

endmodule

// ==== source/blend_pkg.sv ====
// ##############################
// Shared types of the compositor:
// channel, colour, address and
// the source and result entries.
// ##############################

`include "blend_settings.svh"

package blend_pkg;

	typedef logic [`BLEND_CHANNEL_W-1:0] channel_t;

	// Red in the top byte, same layout as the Wishbone data bus.
	typedef struct packed
	{
		channel_t r;
		channel_t g;
		channel_t b;
	} rgb_t;

	typedef logic [`BLEND_PIXEL_ADDR_W-1:0] pixel_addr_t;

	typedef struct packed
	{
		pixel_addr_t addr;  // Frame-buffer location.
		rgb_t rgb;          // Source colour.
		channel_t alpha;    // Straight alpha.
		logic last;         // Last pixel of the frame.
	} src_entry_t;

	typedef struct packed
	{
		pixel_addr_t addr;  // Write-back location.
		rgb_t rgb;          // Blended colour.
		logic last;         // Closes the frame on write ack.
	} res_entry_t;

endpackage

// ==== source/blend_sequencer.sv ====
// ##############################
// blend_sequencer: Wishbone
// classic master. Picks reads or
// write-backs, issues the blend,
// keeps result credits and the
// frame barrier.
// ##############################

`include "blend_settings.svh"

module blend_sequencer
(
	input logic clk,
	input logic reset,
	input logic src_empty,
	input blend_pkg::src_entry_t src_head,
	output logic src_pop,
	output logic blend_valid,
	output blend_pkg::rgb_t blend_src,
	output blend_pkg::channel_t blend_alpha,
	output blend_pkg::rgb_t blend_dst,
	output blend_pkg::res_entry_t blend_tag,
	input logic [1:0] pipe_in_flight,
	input logic [$clog2(`BLEND_RES_DEPTH):0] res_count,
	input blend_pkg::res_entry_t res_head,
	output logic res_pop,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output blend_pkg::pixel_addr_t wb_adr,
	output blend_pkg::rgb_t wb_dat_w,
	input blend_pkg::rgb_t wb_dat_r,
	input logic wb_ack,
	output logic frame_done
);

	import blend_pkg::*;

	localparam int OCC_W = $clog2(`BLEND_RES_DEPTH) + 2;

	typedef enum logic [1:0]
	{
		ST_IDLE,
		ST_READ,
		ST_WRITE
	} state_t;

	state_t state;
	logic res_empty;
	logic [OCC_W-1:0] occupancy;
	logic credit_ok;
	logic barrier;
	logic start_write;
	logic start_read;
	logic read_done;
	logic write_done;

	assign res_empty = (res_count == '0);

	// A blend waiting to enter the pipe already holds a result slot.
	assign occupancy = OCC_W'(pipe_in_flight) + OCC_W'(res_count) + OCC_W'(blend_valid);
	assign credit_ok = (occupancy < `BLEND_RES_DEPTH);

	assign start_write = (state == ST_IDLE) && !res_empty;  // Write-back has priority.
	assign start_read = (state == ST_IDLE) && res_empty && !src_empty && !barrier && credit_ok;
	assign read_done = (state == ST_READ) && wb_ack;
	assign write_done = (state == ST_WRITE) && wb_ack;

	assign src_pop = read_done;
	assign res_pop = write_done;

	assign wb_cyc = (state != ST_IDLE);
	assign wb_stb = (state != ST_IDLE);  // Single transfer per cycle, so stb follows cyc.
	assign wb_we = (state == ST_WRITE);

	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			state <= ST_IDLE;
			barrier <= 1'b0;
			blend_valid <= 1'b0;
			frame_done <= 1'b0;
		end
		else
		begin
			blend_valid <= read_done;  // Issue one cycle after the read ack.
			frame_done <= write_done && res_head.last;
			case (state)
				ST_IDLE:
				begin
					if (start_write)
						state <= ST_WRITE;
					else if (start_read)
						state <= ST_READ;
				end
				ST_READ,
				ST_WRITE:
				begin
					if (wb_ack)
						state <= ST_IDLE;  // Bus drops for one cycle after ack.
				end
				default:
					state <= ST_IDLE;
			endcase
			if (read_done && src_head.last)
				barrier <= 1'b1;  // Next frame waits for the last write.
			else if (write_done && res_head.last)
				barrier <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (start_write)
		begin
			wb_adr <= res_head.addr;
			wb_dat_w <= res_head.rgb;
		end
		else if (start_read)
			wb_adr <= src_head.addr;
		if (read_done)
		begin
			blend_src <= src_head.rgb;
			blend_alpha <= src_head.alpha;
			blend_dst <= wb_dat_r;  // Read data is valid in the ack cycle.
			blend_tag.addr <= src_head.addr;
			blend_tag.rgb <= '0;
			blend_tag.last <= src_head.last;
		end
	end

	assert property (@(posedge clk) disable iff (!reset) wb_stb |-> wb_cyc)
		else $error("blend_sequencer: stb without cyc.");

endmodule

// ==== source/blend_settings.svh ====
// ##############################
// Compile-time settings for the
// alpha compositing engine:
// channel and address widths,
// queue depths, blend latency.
// ##############################

`ifndef BLEND_SETTINGS_SVH
`define BLEND_SETTINGS_SVH

// Bits per colour channel and per alpha value.
`define BLEND_CHANNEL_W 8

// Frame-buffer address width.
`define BLEND_PIXEL_ADDR_W 12

// Source and result queue depths.
`define BLEND_SRC_DEPTH 4
`define BLEND_RES_DEPTH 4

// Blend pipe stages: multiply, add, divide.
`define BLEND_LATENCY 3

`endif

// ==== source/entry_fifo.sv ====
// ##############################
// entry_fifo: synchronous FIFO
// on a type parameter, with an
// occupancy count output.
// ##############################

module entry_fifo
#(
	parameter type entry_t = logic,
	parameter int DEPTH = 4
)
(
	input logic clk,
	input logic reset,
	input logic push,
	input entry_t push_data,
	input logic pop,
	output entry_t head,
	output logic full,
	output logic empty,
	output logic [$clog2(DEPTH):0] count
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	entry_t mem [DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;

	function automatic logic [PTR_W-1:0] bump(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;  // Wrap for any depth.
	endfunction

	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= bump(wr_ptr);
			if (pop)
				rd_ptr <= bump(rd_ptr);
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	assign head = mem[rd_ptr];  // Valid whenever not empty.
	assign full = (count == DEPTH);
	assign empty = (count == '0);

	assert property (@(posedge clk) disable iff (!reset) push |-> !full)
		else $error("entry_fifo: push into a full queue.");
	assert property (@(posedge clk) disable iff (!reset) pop |-> !empty)
		else $error("entry_fifo: pop from an empty queue.");

endmodule

// ==== test/compositor_tb.sv ====
// ##############################
// compositor_tb: clock, reset,
// LFSR stimulus, blend model,
// bus monitor, compare tasks,
// timeout and verdict.
// ##############################

module compositor_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import blend_pkg::*;

	localparam int FRAMES = 12;
	localparam int FRAME_PIXELS = 16;
	localparam int NUM_PIXELS = FRAMES * FRAME_PIXELS;
	localparam int CYCLE_LIMIT = NUM_PIXELS * 20 + 200;
	localparam int IMAGE_SIZE = 2 ** $bits(pixel_addr_t);

	logic clk;
	logic reset;
	logic src_valid;
	logic src_ready;
	pixel_addr_t src_addr;
	channel_t src_r;
	channel_t src_g;
	channel_t src_b;
	channel_t src_a;
	logic src_last;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	pixel_addr_t wb_adr;
	rgb_t wb_dat_w;
	rgb_t wb_dat_r;
	logic wb_ack;
	logic frame_done;
	logic [1:0] wait_cycles;
	logic stall;

	logic [31:0] lfsr = 32'h28c3_f6e7;
	pixel_addr_t pix_addr [NUM_PIXELS];
	rgb_t pix_rgb [NUM_PIXELS];
	channel_t pix_alpha [NUM_PIXELS];
	rgb_t model_img [IMAGE_SIZE];
	int sent = 0;
	int reads_seen = 0;
	int writes_seen = 0;
	int frames_done = 0;
	int cycles = 0;
	int stall_left = 0;
	logic done_expected = 1'b0;
	logic saw_full = 1'b0;

	alpha_compositor dut
	(
		.clk(clk), .reset(reset),
		.src_valid(src_valid), .src_ready(src_ready), .src_addr(src_addr),
		.src_r(src_r), .src_g(src_g), .src_b(src_b), .src_a(src_a), .src_last(src_last),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.frame_done(frame_done)
	);

	frame_memory_model mem
	(
		.clk(clk), .reset(reset), .wait_cycles(wait_cycles), .stall(stall),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
	);

	// Galois form, taps for x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic int unsigned take_bits(input int n);
		int unsigned v;
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			v = (v << 1) | lfsr[0];  // One step per bit.
		end
		return v;
	endfunction

	function automatic channel_t blend_channel(input channel_t s, input channel_t d,
		input channel_t a);
		int unsigned num;
		num = s * a + d * (255 - a);
		return channel_t'(num / 255);  // Truncating quotient.
	endfunction

	function automatic rgb_t blend_rgb(input rgb_t s, input rgb_t d, input channel_t a);
		rgb_t r;
		r.r = blend_channel(s.r, d.r, a);
		r.g = blend_channel(s.g, d.g, a);
		r.b = blend_channel(s.b, d.b, a);
		return r;
	endfunction

	task automatic abort_run();
		$display("CHECKS FAILED");
		$fatal(1, "Simulation stopped at the first failure.");
	endtask

	task automatic compare_rgb(input rgb_t got, input rgb_t want, input string what);
		if (got !== want)
		begin
			$display("[ERROR] %0t ns: %s is %h, expected %h.", $time, what, got, want);
			abort_run();
		end
	endtask

	task automatic expect_addr(input pixel_addr_t got, input pixel_addr_t want,
		input string what);
		if (got !== want)
		begin
			$display("[ERROR] %0t ns: %s is %h, expected %h.", $time, what, got, want);
			abort_run();
		end
	endtask

	task automatic verify_count(input int got, input int want, input string what);
		if (got !== want)
		begin
			$display("[ERROR] %0t ns: %s is %0d, expected %0d.", $time, what, got, want);
			abort_run();
		end
	endtask

	task automatic ensure_pixel_left(input int idx, input string what);
		if (idx >= NUM_PIXELS)
		begin
			$display("The DUT made a %s transfer after the last pixel was handled.", what);
			abort_run();
		end
	endtask

	task automatic init_image();
		for (int a = 0; a < IMAGE_SIZE; a++)
		begin
			model_img[a] = rgb_t'(take_bits(24));
			mem.ram[a] = model_img[a];
		end
	endtask

	task automatic build_frames();
		bit used [IMAGE_SIZE];
		pixel_addr_t a;
		int p;
		for (int f = 0; f < FRAMES; f++)
		begin
			used = '{default: 1'b0};  // Addresses are distinct per frame only.
			for (int i = 0; i < FRAME_PIXELS; i++)
			begin
				p = f * FRAME_PIXELS + i;
				a = pixel_addr_t'(take_bits($bits(pixel_addr_t)));
				while (used[a])
					a = pixel_addr_t'(take_bits($bits(pixel_addr_t)));
				used[a] = 1'b1;
				pix_addr[p] = a;
				pix_rgb[p] = rgb_t'(take_bits(24));
				pix_alpha[p] = channel_t'(take_bits(8));
				if (i == 2)
					pix_alpha[p] = 8'd255;  // Opaque.
				if (i == 9)
					pix_alpha[p] = 8'd0;  // Fully transparent.
			end
		end
	endtask

	task automatic present_pixel(input int p);
		src_valid <= 1'b1;
		src_addr <= pix_addr[p];
		src_r <= pix_rgb[p].r;
		src_g <= pix_rgb[p].g;
		src_b <= pix_rgb[p].b;
		src_a <= pix_alpha[p];
		src_last <= (p % FRAME_PIXELS == FRAME_PIXELS - 1);
	endtask

	// Fresh wait count each cycle, plus rare long stall bursts.
	task automatic drive_bus_timing();
		wait_cycles <= 2'(take_bits(2));
		if (stall_left > 0)
			stall_left--;
		else if (take_bits(7) == 0)
			stall_left = 24 + take_bits(3);
		stall <= (stall_left > 0);
	endtask

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > CYCLE_LIMIT)
		begin
			$display("Timeout: the run did not finish within %0d cycles.", CYCLE_LIMIT);
			abort_run();
		end
	end

	// Bus monitor against the model image.
	always @(posedge clk)
	begin
		rgb_t expected;
		int w;
		if (reset)
		begin
			if (!src_ready)
				saw_full = 1'b1;
			verify_count(int'(frame_done), int'(done_expected), "frame_done");
			done_expected = 1'b0;
			if (frame_done)
				frames_done++;
			if (wb_stb && !wb_we)
				verify_count(frames_done, reads_seen / FRAME_PIXELS, "frame of a pending read");
			if (wb_stb && wb_ack && !wb_we)
			begin
				ensure_pixel_left(reads_seen, "read");
				expect_addr(wb_adr, pix_addr[reads_seen], "read address");
				reads_seen++;
			end
			if (wb_stb && wb_ack && wb_we)
			begin
				ensure_pixel_left(writes_seen, "write");
				w = writes_seen;
				expect_addr(wb_adr, pix_addr[w], "write address");
				if (pix_alpha[w] == 8'd255)
					compare_rgb(wb_dat_w, pix_rgb[w], "opaque pixel colour");
				else if (pix_alpha[w] == 8'd0)
					compare_rgb(wb_dat_w, model_img[pix_addr[w]], "transparent pixel colour");
				expected = blend_rgb(pix_rgb[w], model_img[pix_addr[w]], pix_alpha[w]);
				compare_rgb(wb_dat_w, expected, "written colour");
				model_img[pix_addr[w]] = expected;
				done_expected = (w % FRAME_PIXELS == FRAME_PIXELS - 1);
				writes_seen++;
			end
		end
	end

	initial
	begin
		reset = 1'b0;
		src_valid = 1'b0;
		src_addr = '0;
		src_r = '0;
		src_g = '0;
		src_b = '0;
		src_a = '0;
		src_last = 1'b0;
		wait_cycles = '0;
		stall = 1'b0;
		init_image();
		build_frames();
		repeat (3) @(posedge clk);
		reset <= 1'b1;
		repeat (2) @(posedge clk);
		verify_count(int'(wb_cyc), 0, "wb_cyc after reset");
		verify_count(int'(wb_stb), 0, "wb_stb after reset");
		verify_count(int'(wb_we), 0, "wb_we after reset");
		verify_count(int'(frame_done), 0, "frame_done after reset");
		verify_count(int'(src_ready), 1, "src_ready after reset");
		while (writes_seen < NUM_PIXELS || frames_done < FRAMES)
		begin
			@(posedge clk);
			drive_bus_timing();
			if (src_valid && src_ready)
				sent++;  // Handshake at this edge.
			if (!src_valid || src_ready)
			begin
				if (sent < NUM_PIXELS && take_bits(2) != 0)
					present_pixel(sent);
				else
					src_valid <= 1'b0;
			end
		end
		repeat (2) @(posedge clk);
		verify_count(sent, NUM_PIXELS, "accepted pixels");
		for (int a = 0; a < IMAGE_SIZE; a++)
			compare_rgb(mem.ram[a], model_img[a], "final memory word");
		if (!saw_full)
		begin
			$display("The source FIFO never filled, so back-pressure was not exercised.");
			abort_run();
		end
		else
		begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

// ==== test/frame_memory_model.sv ====
// ##############################
// frame_memory_model: Wishbone
// classic slave frame buffer.
// Wait states and stall bursts
// come from the testbench.
// ##############################

module frame_memory_model
(
	input logic clk,
	input logic reset,
	input logic [1:0] wait_cycles,
	input logic stall,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input blend_pkg::pixel_addr_t wb_adr,
	input blend_pkg::rgb_t wb_dat_w,
	output blend_pkg::rgb_t wb_dat_r,
	output logic wb_ack
);

	timeunit 1ns;
	timeprecision 1ps;

	import blend_pkg::*;

	rgb_t ram [2 ** $bits(pixel_addr_t)];  // Loaded by the testbench at time zero.
	logic busy;
	logic [1:0] held;
	logic [1:0] waited;
	logic [1:0] target;

	assign target = busy ? held : wait_cycles;  // Wait count fixed per transfer.

	always @(posedge clk)
	begin
		if (!reset)
		begin
			wb_ack <= 1'b0;
			busy <= 1'b0;
			waited <= '0;
		end
		else
		begin
			wb_ack <= 1'b0;
			if (wb_cyc && wb_stb && !wb_ack)
			begin
				if (waited == target && !stall)
				begin
					wb_ack <= 1'b1;
					busy <= 1'b0;
					waited <= '0;
					if (wb_we)
						ram[wb_adr] <= wb_dat_w;
					wb_dat_r <= ram[wb_adr];  // Valid in the ack cycle.
				end
				else
				begin
					busy <= 1'b1;
					held <= target;
					if (waited != target)
						waited <= waited + 1'b1;
				end
			end
		end
	end

endmodule
